//--- sim.f
+incdir+logic
logic/sigmoid_pkg.sv
logic/elem_fifo.sv
logic/lane_roller.sv
logic/sigmoid_plan.sv
logic/fixed_sigmoid.sv
tests/fixed_sigmoid_sva.sv
tests/fixed_sigmoid_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert -f sim.f --top-module fixed_sigmoid_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vfixed_sigmoid_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '** FAIL **' "$log"; then
  echo "Simulation reported failure, see $log"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- tests/fixed_sigmoid_tb.sv
`include "sigmoid_cfg.svh"

module fixed_sigmoid_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NL     = `SIG_IN_LANES;
  localparam int NO     = `SIG_OUT_LANES;
  localparam int NSL    = `SIG_IN_LANES / `SIG_OUT_LANES;
  localparam int NTAB   = 6;
  localparam int NRAND  = 32;
  localparam int NBEATS = NTAB + NRAND;
  localparam int NOUT   = NBEATS * NSL;
  localparam int LIMIT  = 4 * NOUT + 100;

  // Rows list lanes 0 to 3 as Q4.4 hex; breakpoints 1, 2.375 and 5 with their neighbours.
  localparam logic [`SIG_WORD_W-1:0] TAB_IN [NTAB][NL] = '{
    '{8'h00, 8'h01, 8'hFF, 8'h10},
    '{8'hF0, 8'h0F, 8'hF1, 8'h26},
    '{8'hDA, 8'h25, 8'hDB, 8'h50},
    '{8'hB0, 8'h80, 8'h7F, 8'h4F},
    '{8'hB1, 8'h81, 8'h00, 8'h26},
    '{8'h01, 8'hFF, 8'h10, 8'hF0}
  };
  localparam logic [`SIG_WORD_W-1:0] TAB_EXP [NTAB][NL] = '{
    '{8'h08, 8'h08, 8'h08, 8'h0C},
    '{8'h04, 8'h0C, 8'h04, 8'h0F},
    '{8'h01, 8'h0F, 8'h01, 8'h10},
    '{8'h00, 8'h00, 8'h10, 8'h10},
    '{8'h00, 8'h00, 8'h08, 8'h0F},
    '{8'h08, 8'h08, 8'h0C, 8'h04}
  };

  logic                       clk;
  logic                       rst_n;
  sigmoid_pkg::sig_in_beat_t  in_beat;
  logic                       in_valid;
  logic                       in_ready;
  sigmoid_pkg::sig_out_beat_t out_beat;
  logic                       out_valid;
  logic                       out_ready;

  sigmoid_pkg::sig_in_beat_t  stim [NBEATS];
  sigmoid_pkg::sig_in_beat_t  want [NBEATS];
  sigmoid_pkg::sig_out_beat_t exp_q [$];
  sigmoid_pkg::sig_out_beat_t src_q [$];  // Input words in rolled order.
  sigmoid_pkg::sig_out_beat_t exp_b;
  sigmoid_pkg::sig_out_beat_t src_b;
  sigmoid_pkg::sig_word_u     res_of [256];
  logic                       seen [256] = '{default: 1'b0};
  logic                       saw_full = 1'b0;
  logic [31:0]                lfsr;
  int                         val_errs = 0;
  int                         word_errs = 0;
  int                         flag_errs = 0;
  int                         other_errs = 0;
  int                         rcv_cnt = 0;

  fixed_sigmoid UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_beat (out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
  endfunction

  // Exact in 1/512 steps, so the rounding matches a Q.8 datapath.
  function automatic logic [`SIG_WORD_W-1:0] ref_sigmoid(input logic [`SIG_WORD_W-1:0] w);
    int x;
    int m;
    int acc;
    int pos;
    x = int'($signed(w));
    m = (x < 0) ? -x : x;
    if (m >= 80) begin
      acc = 512;
    end else if (m >= 38) begin
      acc = m + 432;            // m/32 + 0.84375.
    end else if (m >= 16) begin
      acc = 4 * m + 320;        // m/8 + 0.625.
    end else begin
      acc = 8 * m + 256;        // m/4 + 0.5.
    end
    pos = (acc + 16) / 32;
    if (x < 0) begin
      pos = 16 - pos;
    end
    return pos[`SIG_WORD_W-1:0];
  endfunction

  task automatic check_out(input sigmoid_pkg::sig_out_beat_t got,
                           input sigmoid_pkg::sig_out_beat_t expv, input int idx);
    if (got !== expv) begin
      $display("ERR %0t ns: output beat %0d is %h, expected %h", $time, idx, got, expv);
      val_errs++;
    end
  endtask

  task automatic check_word(input string what, input sigmoid_pkg::sig_word_u got,
                            input sigmoid_pkg::sig_word_u expv);
    if (got !== expv) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, expv);
      word_errs++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic expv);
    if (got !== expv) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, expv);
      flag_errs++;
    end
  endtask

  // Scoreboard.
  always @(posedge clk) begin
    if (rst_n && in_valid && !in_ready) begin
      saw_full = 1'b1;
    end
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output beat at %0t ns arrived with no beat left to expect", $time);
        other_errs++;
      end else begin
        exp_b = exp_q.pop_front();
        src_b = src_q.pop_front();
        check_out(out_beat, exp_b, rcv_cnt);
        for (int j = 0; j < NO; j++) begin
          seen[$unsigned(src_b.lanes[j].raw)] = 1'b1;
          res_of[$unsigned(src_b.lanes[j].raw)] = out_beat.lanes[j];
        end
        rcv_cnt++;
      end
    end
  end

  initial begin : stimulus
    sigmoid_pkg::sig_out_beat_t part;
    sigmoid_pkg::sig_out_beat_t part_in;
    sigmoid_pkg::sig_word_u     sum;
    int                         sent;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    lfsr      = 32'h3c8d_f2ac;
    for (int r = 0; r < NTAB; r++) begin
      for (int l = 0; l < NL; l++) begin
        stim[r].lanes[l].raw = TAB_IN[r][l];
        want[r].lanes[l].raw = TAB_EXP[r][l];
        check_word("reference model on table", ref_sigmoid(TAB_IN[r][l]), TAB_EXP[r][l]);
      end
    end
    for (int r = NTAB; r < NBEATS; r++) begin
      for (int l = 0; l < NL; l++) begin
        for (int b = 0; b < `SIG_WORD_W; b++) begin
          lfsr = lfsr_step(lfsr);
          stim[r].lanes[l].raw[b] = lfsr[0];
        end
        want[r].lanes[l].raw = ref_sigmoid(stim[r].lanes[l].raw);
      end
    end
    for (int r = 0; r < NBEATS; r++) begin
      for (int s = 0; s < NSL; s++) begin
        for (int j = 0; j < NO; j++) begin
          part.lanes[j]    = want[r].lanes[s * NO + j];
          part_in.lanes[j] = stim[r].lanes[s * NO + j];
        end
        exp_q.push_back(part);
        src_q.push_back(part_in);
      end
    end

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_flag("out_valid after reset", out_valid, 1'b0);
    check_flag("in_ready after reset", in_ready, 1'b1);

    sent = 0;
    while (rcv_cnt < NOUT) begin
      if (in_valid && in_ready) begin
        sent++;
      end
      if (sent < NBEATS) begin
        in_valid <= 1'b1;
        in_beat  <= stim[sent];
      end else begin
        in_valid <= 1'b0;
      end
      lfsr = lfsr_step(lfsr);
      out_ready <= lfsr[0];
      @(posedge clk);
    end
    repeat (4) @(posedge clk);  // Catch any extra beat.

    check_flag("in_ready low while full", saw_full, 1'b1);
    for (int x = 1; x < 128; x++) begin
      if (seen[x] && seen[256 - x]) begin
        sum.raw = res_of[x].raw + res_of[256 - x].raw;
        check_word("sum of x and -x results", sum, 8'd16);
      end
    end
    for (int x = 80; x < 128; x++) begin
      if (seen[x]) begin
        check_word("positive saturation", res_of[x], 8'd16);
      end
    end
    for (int x = 128; x <= 176; x++) begin
      if (seen[x]) begin
        check_word("negative saturation", res_of[x], 8'd0);
      end
    end

    $display("Errors: %0d beat, %0d word, %0d flag, %0d other; %0d of %0d beats received",
             val_errs, word_errs, flag_errs, other_errs, rcv_cnt, NOUT);
    if (val_errs + word_errs + flag_errs + other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: output stalled, %0d of %0d beats received after %0d cycles",
             rcv_cnt, NOUT, cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- tests/fixed_sigmoid_sva.sv
module fixed_sigmoid_sva (
  input logic                       clk,
  input logic                       rst_n,
  input sigmoid_pkg::sig_in_beat_t  in_beat,
  input logic                       in_valid,
  input logic                       in_ready,
  input sigmoid_pkg::sig_out_beat_t out_beat,
  input logic                       out_valid,
  input logic                       out_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  in_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid)
    else $error("in_valid dropped before its transfer");

  in_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> $stable(in_beat))
    else $error("in_beat changed while waiting for in_ready");

  out_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid dropped before its transfer");

  out_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> $stable(out_beat))
    else $error("out_beat changed while waiting for out_ready");

  // Reset is asynchronous, so the flag is already low at the first edge.
  out_valid_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind fixed_sigmoid fixed_sigmoid_sva sva_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_beat  (in_beat),
  .in_valid (in_valid),
  .in_ready (in_ready),
  .out_beat (out_beat),
  .out_valid(out_valid),
  .out_ready(out_ready)
);

//--- logic/fixed_sigmoid.sv
`include "sigmoid_cfg.svh"

module fixed_sigmoid (
  input  logic                       clk,
  input  logic                       rst_n,
  input  sigmoid_pkg::sig_in_beat_t  in_beat,
  input  logic                       in_valid,
  output logic                       in_ready,
  output sigmoid_pkg::sig_out_beat_t out_beat,
  output logic                       out_valid,
  input  logic                       out_ready
);

  sigmoid_pkg::sig_in_beat_t  fifo_beat;
  logic                       fifo_valid;
  logic                       fifo_ready;
  sigmoid_pkg::sig_out_beat_t roll_beat;
  logic                       roll_valid;
  logic                       roll_ready;

  elem_fifo #(
    .DEPTH(`SIG_FIFO_DEPTH)
  ) buffer_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_beat (in_beat),
    .wr_valid(in_valid),
    .wr_ready(in_ready),
    .rd_beat (fifo_beat),
    .rd_valid(fifo_valid),
    .rd_ready(fifo_ready)
  );

  lane_roller #(
    .IN_LANES (`SIG_IN_LANES),
    .OUT_LANES(`SIG_OUT_LANES)
  ) roller_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (fifo_beat),
    .in_valid (fifo_valid),
    .in_ready (fifo_ready),
    .out_beat (roll_beat),
    .out_valid(roll_valid),
    .out_ready(roll_ready)
  );

  for (genvar i = 0; i < `SIG_OUT_LANES; i++) begin : g_sigmoid
    sigmoid_plan sigmoid_map (
      .x(roll_beat.lanes[i]),
      .y(out_beat.lanes[i].raw)
    );
  end

  // Sigmoid units are combinational, so the handshake passes straight through.
  assign out_valid  = roll_valid;
  assign roll_ready = out_ready;

endmodule

//--- logic/sigmoid_plan.sv
`include "sigmoid_cfg.svh"

module sigmoid_plan (
  input  sigmoid_pkg::sig_word_u x,
  output logic [`SIG_WORD_W-1:0] y
);

  localparam int WW    = `SIG_WORD_W;
  localparam int FW    = `SIG_FRAC_W;
  localparam int EXT_W = FW + 4;       // Fraction bits while computing.
  localparam int ACC_W = WW + 4;

  // Segment offsets in Q.8, fixed for a Q4.4 word.
  localparam logic [ACC_W-1:0] OFS_LOW  = ACC_W'(128);  // 0.5.
  localparam logic [ACC_W-1:0] OFS_MID  = ACC_W'(160);  // 0.625.
  localparam logic [ACC_W-1:0] OFS_HIGH = ACC_W'(216);  // 0.84375.
  localparam logic [ACC_W-1:0] ONE_EXT  = ACC_W'(1) << EXT_W;
  localparam logic [ACC_W-1:0] HALF_LSB = ACC_W'(1) << (EXT_W - FW - 1);
  localparam logic [WW-1:0]    ONE_OUT  = WW'(1) << FW;

  localparam int SAT_INT   = 5;
  localparam int HIGH_INT  = 2;
  localparam int HIGH_FRAC = 6;  // 2.375 has fraction 6/16.
  localparam int MID_INT   = 1;

  sigmoid_pkg::sig_word_u mag;
  logic                   neg;
  logic [ACC_W-1:0]       mag_ext;
  logic [ACC_W-1:0]       acc;
  logic [ACC_W-1:0]       rnd;
  logic [WW-1:0]          y_pos;

  always_comb begin
    neg = x.raw[WW-1];
    if (!neg) begin
      mag.raw = x.raw;
    end else if (x.raw == {1'b1, {(WW-1){1'b0}}}) begin
      mag.raw = {1'b0, {(WW-1){1'b1}}};  // -8 has no positive twin, clamp it.
    end else begin
      mag.raw = -x.raw;
    end
  end

  assign mag_ext = {{(ACC_W-WW){1'b0}}, mag.raw};

  always_comb begin
    if (mag.fx.int_part >= SAT_INT) begin
      acc = ONE_EXT;
    end else if (mag.fx.int_part > HIGH_INT ||
                 (mag.fx.int_part == HIGH_INT && mag.fx.frac_part >= HIGH_FRAC)) begin
      acc = (mag_ext >> 1) + OFS_HIGH;  // Slope 1/32.
    end else if (mag.fx.int_part >= MID_INT) begin
      acc = (mag_ext << 1) + OFS_MID;   // Slope 1/8.
    end else begin
      acc = (mag_ext << 2) + OFS_LOW;   // Slope 1/4.
    end
  end

  // Round half up back to Q4.4.
  assign rnd   = acc + HALF_LSB;
  assign y_pos = rnd[ACC_W-1:EXT_W-FW];
  assign y     = neg ? ONE_OUT - y_pos : y_pos;

endmodule

//--- logic/lane_roller.sv
`include "sigmoid_cfg.svh"

module lane_roller #(
  parameter int IN_LANES  = `SIG_IN_LANES,
  parameter int OUT_LANES = `SIG_OUT_LANES
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  sigmoid_pkg::sig_in_beat_t  in_beat,
  input  logic                       in_valid,
  output logic                       in_ready,
  output sigmoid_pkg::sig_out_beat_t out_beat,
  output logic                       out_valid,
  input  logic                       out_ready
);

  localparam int NUM_SLICES = IN_LANES / OUT_LANES;
  localparam int IDX_W      = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

  if (IN_LANES == OUT_LANES) begin : g_slice
    sigmoid_pkg::sig_out_beat_t data_q;
    logic                       valid_q;

    assign in_ready  = ~valid_q | out_ready;
    assign out_valid = valid_q;
    assign out_beat  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
      end else if (in_ready) begin
        valid_q <= in_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
        for (int j = 0; j < OUT_LANES; j++) begin
          data_q.lanes[j] <= in_beat.lanes[j];
        end
      end
    end
  end else begin : g_roll
    sigmoid_pkg::sig_in_beat_t beat_q;
    logic [IDX_W-1:0]          idx_q;
    logic                      valid_q;
    logic                      last;

    assign last      = (idx_q == IDX_W'(NUM_SLICES - 1));
    assign in_ready  = ~valid_q | (out_ready & last);  // Reload on the final slice.
    assign out_valid = valid_q;

    always_comb begin
      for (int j = 0; j < OUT_LANES; j++) begin
        out_beat.lanes[j] = beat_q.lanes[int'(idx_q) * OUT_LANES + j];
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
        idx_q   <= '0;
      end else if (in_valid && in_ready) begin
        valid_q <= 1'b1;
        idx_q   <= '0;
      end else if (valid_q && out_ready) begin
        idx_q <= idx_q + 1'b1;
        if (last) begin
          valid_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
        beat_q <= in_beat;
      end
    end
  end

endmodule

//--- logic/elem_fifo.sv
`include "sigmoid_cfg.svh"

module elem_fifo #(
  parameter int DEPTH = `SIG_FIFO_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  sigmoid_pkg::sig_in_beat_t wr_beat,
  input  logic                      wr_valid,
  output logic                      wr_ready,
  output sigmoid_pkg::sig_in_beat_t rd_beat,
  output logic                      rd_valid,
  input  logic                      rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  sigmoid_pkg::sig_in_beat_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] arr_cnt;  // Beats in the array, not counting the output stage.
  logic             wr_fire;
  logic             stage_free;
  logic             bypass;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Output stage counts toward the occupancy limit.
  assign wr_ready   = (arr_cnt + CNT_W'(rd_valid)) < CNT_W'(DEPTH);
  assign wr_fire    = wr_valid & wr_ready;
  assign stage_free = ~rd_valid | rd_ready;
  assign pop        = stage_free & (arr_cnt != '0);
  assign bypass     = stage_free & (arr_cnt == '0) & wr_fire;  // Skip the array when empty.
  assign push       = wr_fire & ~bypass;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      arr_cnt  <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      arr_cnt <= arr_cnt + CNT_W'(push) - CNT_W'(pop);
      if (stage_free) begin
        rd_valid <= pop | bypass;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_beat;
    end
    if (pop) begin
      rd_beat <= mem[rd_ptr];  // Head of the array refills the stage.
    end else if (bypass) begin
      rd_beat <= wr_beat;
    end
  end

endmodule

//--- logic/sigmoid_pkg.sv
`include "sigmoid_cfg.svh"

package sigmoid_pkg;

  typedef struct packed {
    logic signed [`SIG_WORD_W-`SIG_FRAC_W-1:0] int_part;  // Two's complement integer.
    logic [`SIG_FRAC_W-1:0]                    frac_part;
  } sig_fx_t;

  // One Q4.4 word, seen whole or split at the binary point.
  typedef union packed {
    logic signed [`SIG_WORD_W-1:0] raw;
    sig_fx_t                       fx;
  } sig_word_u;

  typedef struct packed {
    sig_word_u [`SIG_IN_LANES-1:0] lanes;
  } sig_in_beat_t;

  typedef struct packed {
    sig_word_u [`SIG_OUT_LANES-1:0] lanes;
  } sig_out_beat_t;

endpackage

//--- logic/sigmoid_cfg.svh
`ifndef SIGMOID_CFG_SVH
`define SIGMOID_CFG_SVH

// Fixed-point word format, signed Q4.4 in and unsigned Q4.4 out.
`define SIG_WORD_W 8
`define SIG_FRAC_W 4

// Words per beat on each side of the lane roller.
`define SIG_IN_LANES 4
`define SIG_OUT_LANES 2  // Must divide SIG_IN_LANES.

// Input beats held by the element FIFO.
`define SIG_FIFO_DEPTH 4

`endif
